//--- robot_drive.f
+incdir+tb
common/robot_pkg.sv
hw/tick_generator.sv
hw/mecanum_kinematics.sv
wheel/pwm_driver.sv
wheel/encoder_counter.sv
hw/robot_drive.sv
tb/tb_robot_drive.sv

//--- Makefile
# Verilator build and run of the drive chain testbench
# Any variable can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_robot_drive
FILELIST  ?= robot_drive.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

# Sources from the file list plus the included model header
SRCS := $(shell grep -v '^+' $(FILELIST)) tb/drive_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass or fail is taken from the log, not from the exit code
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/drive_model.svh
/* Reference model of the drive chain for the testbench
 * robot_pkg must be imported before this header is included
 */
`ifndef DRIVE_MODEL_SVH
`define DRIVE_MODEL_SVH

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Signed value in units of 1/256
function automatic int fix_value(input fix_t f);
	int v;
	v = int'(f.mag_int) * 256 + int'(f.frac);
	return f.sign ? -v : v;  // Negative zero reads as zero
endfunction

// Mixing of the four wheels, index 0 is wheel 1
function automatic int wheel_sum(input twist_t c, input int w);
	int vx;
	int vy;
	int wz;
	vx = fix_value(c.vx);
	vy = fix_value(c.vy);
	wz = fix_value(c.wz);
	case (w)
		0:       return vx + vy + wz;
		1:       return vx - vy - wz;
		2:       return vx - vy + wz;
		default: return vx + vy - wz;
	endcase
endfunction

// Direction and clipped duty of one wheel sum
function automatic wheel_cmd_t expected_cmd(input int s);
	int         mag;
	wheel_cmd_t w;
	mag = (s < 0) ? -s : s;
	mag = mag / 256;            // Integer part, toward zero
	if (mag > 255)
		mag = 255;
	w.duty = DUTY_WIDTH'(mag);
	if (mag == 0)
		w.dir = DIR_STOP;
	else
		w.dir = (s < 0) ? DIR_REV : DIR_FWD;
	return w;
endfunction

// Edges per window for a given pulse period, clipped
function automatic int expected_speed(input int period, input int window);
	int n;
	n = window / period;
	return (n > 255) ? 255 : n;
endfunction

`endif

//--- tb/tb_robot_drive.sv
`timescale 1ns/1ps
/* Testbench of the drive chain with a 2-cycle strobe and a 2048-cycle window
 * Expected values come from drive_model.svh, stimulus from a fixed xorshift seed
 */
module tb_robot_drive;
	import robot_pkg::*;
	`include "drive_model.svh"

	// ==================================================
	// Run parameters
	// ==================================================
	localparam int          PWM_PRESCALE  = 2;
	localparam int          WINDOW_CYCLES = 2048;
	localparam int          PERIOD_CYCLES = 256 * PWM_PRESCALE;  // 512
	localparam int          CLK_NS        = 10;
	localparam int          N_RANDOM      = 12;
	localparam int          N_SMALL       = 4;
	localparam int          N_CMDS        = N_RANDOM + N_SMALL + 3;
	localparam int          CMD_CYCLES    = 6 * PERIOD_CYCLES + 4;  // Settle plus measure
	localparam int          SPEED_WINDOWS = 6;
	localparam int          TIMEOUT_CYCLES =
		2 * (N_CMDS * CMD_CYCLES + SPEED_WINDOWS * WINDOW_CYCLES + 100);
	localparam logic [31:0] SEED          = 32'h2c4b_c128;

	logic                            clock_50;
	logic                            rst_n;
	twist_t                          cmd;
	logic                            cmd_load;
	logic [NUM_WHEELS-1:0]           phase_a = '0;
	logic [NUM_WHEELS-1:0]           pwm;
	motor_dir_t [NUM_WHEELS-1:0]     dir;
	wheel_speeds_t                   speed;

	logic [31:0] rng;
	int          checks;
	int          mismatches;
	logic        enc_run;                               // Encoder pulses on
	int          enc_period [NUM_WHEELS];
	int          enc_count  [NUM_WHEELS] = '{default: 0};

	robot_drive #(
		.PWM_PRESCALE  (PWM_PRESCALE),
		.WINDOW_CYCLES (WINDOW_CYCLES)
	) dut (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.cmd      (cmd),
		.cmd_load (cmd_load),
		.phase_a  (phase_a),
		.pwm      (pwm),
		.dir      (dir),
		.speed    (speed)
	);

	initial clock_50 = 1'b0;
	always #(CLK_NS / 2) clock_50 = ~clock_50;

	// Square wave per wheel, half period high
	always @(posedge clock_50) begin
		for (int w = 0; w < NUM_WHEELS; w++) begin
			if (enc_run) begin
				enc_count[w] <= (enc_count[w] + 1 >= enc_period[w]) ? 0 : enc_count[w] + 1;
				phase_a[w]   <= (enc_count[w] < enc_period[w] / 2);
			end else begin
				enc_count[w] <= 0;
				phase_a[w]   <= 1'b0;
			end
		end
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================
	function logic [31:0] draw_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Wide gives the full integer range, so sums often clip
	function automatic fix_t random_fix(input bit wide);
		logic [31:0] r;
		fix_t        f;
		r         = draw_random();
		f.sign    = r[31];
		f.mag_int = wide ? r[15:8] : {2'b00, r[13:8]};
		f.frac    = r[7:0];
		return f;
	endfunction

	function automatic twist_t random_twist(input bit wide);
		twist_t c;
		c.vx = random_fix(wide);
		c.vy = random_fix(wide);
		c.wz = random_fix(wide);
		return c;
	endfunction

	task automatic load_command(input twist_t c);
		@(posedge clock_50);
		cmd      <= c;
		cmd_load <= 1'b1;
		@(posedge clock_50);
		cmd_load <= 1'b0;
	endtask

	// ==================================================
	// Checks
	// ==================================================
	// Settle 2 periods, then count high cycles over 4 periods
	task automatic check_drive(input twist_t c);
		wheel_cmd_t want    [NUM_WHEELS];
		int         high    [NUM_WHEELS];
		int         dir_bad [NUM_WHEELS];
		int         want_high;
		for (int w = 0; w < NUM_WHEELS; w++) begin
			want[w]    = expected_cmd(wheel_sum(c, w));
			high[w]    = 0;
			dir_bad[w] = 0;
		end
		repeat (2 * PERIOD_CYCLES) @(posedge clock_50);
		repeat (4 * PERIOD_CYCLES) begin
			@(negedge clock_50);  // Outputs stable here
			for (int w = 0; w < NUM_WHEELS; w++) begin
				if (pwm[w])
					high[w]++;
				if (dir[w] != want[w].dir)
					dir_bad[w]++;
			end
		end
		for (int w = 0; w < NUM_WHEELS; w++) begin
			want_high = 4 * int'(want[w].duty) * PWM_PRESCALE;
			checks += 2;
			assert (high[w] == want_high) else begin
				mismatches++;
				$display("MISMATCH t=%0t wheel %0d pwm high %0d cycles, expected %0d",
					$time, w + 1, high[w], want_high);
			end
			assert (dir_bad[w] == 0) else begin
				mismatches++;
				$display("MISMATCH t=%0t wheel %0d dir not %s in %0d cycles",
					$time, w + 1, want[w].dir.name(), dir_bad[w]);
			end
		end
	endtask

	task automatic check_reset_state();
		repeat (8) begin
			@(negedge clock_50);
			checks++;
			assert (pwm == '0 && dir == '0 && speed == '0) else begin
				mismatches++;
				$display("MISMATCH t=%0t reset state pwm=%b dir=%h speed=%h",
					$time, pwm, dir, speed);
			end
		end
	endtask

	// Fresh full window is latched after 3 windows
	task automatic check_speeds(input bit running);
		int want;
		repeat (3 * WINDOW_CYCLES + 16) @(posedge clock_50);
		@(negedge clock_50);
		for (int w = 0; w < NUM_WHEELS; w++) begin
			want = running ? expected_speed(enc_period[w], WINDOW_CYCLES) : 0;
			checks++;
			assert (int'(speed[w]) >= want - 1 && int'(speed[w]) <= want + 1) else begin
				mismatches++;
				$display("MISMATCH t=%0t wheel %0d speed %0d, expected %0d +-1",
					$time, w + 1, speed[w], want);
			end
		end
	endtask

	// ==================================================
	// Test sequences
	// ==================================================
	task automatic run_random_commands();
		twist_t c;
		for (int i = 0; i < N_RANDOM; i++) begin
			if (i == 0)
				c = {3{1'b0, 8'hff, 8'hff}};     // All clip at 255
			else
				c = random_twist(i % 3 == 1);
			load_command(c);
			check_drive(c);
		end
	endtask

	// Every sum stays below one count
	task automatic run_zero_commands();
		twist_t c;
		for (int i = 0; i < N_SMALL; i++) begin
			c         = random_twist(1'b0);
			c.vx.mag_int = '0;
			c.vy.mag_int = '0;
			c.wz.mag_int = '0;
			c.vx.frac = 8'(int'(c.vx.frac) % 86);  // 3 x 85 < 256
			c.vy.frac = 8'(int'(c.vy.frac) % 86);
			c.wz.frac = 8'(int'(c.wz.frac) % 86);
			load_command(c);
			check_drive(c);
		end
		c = {3{1'b1, 8'h00, 8'h00}};            // Negative zero
		load_command(c);
		check_drive(c);
		// Wheels 1 and 4 cancel to a fraction, 2 and 3 drive
		c.vx = '{sign: 1'b0, mag_int: 8'd3, frac: 8'h40};
		c.vy = '{sign: 1'b1, mag_int: 8'd3, frac: 8'h40};
		c.wz = '{sign: 1'b0, mag_int: 8'd0, frac: 8'h80};
		load_command(c);
		check_drive(c);
	endtask

	task automatic run_back_to_back();
		twist_t first;
		twist_t second;
		first  = random_twist(1'b1);
		second = random_twist(1'b0);
		@(posedge clock_50);
		cmd      <= first;
		cmd_load <= 1'b1;
		@(posedge clock_50);
		cmd      <= second;                    // Load held high
		@(posedge clock_50);
		cmd_load <= 1'b0;
		check_drive(second);
	endtask

	task automatic run_speed_tests();
		for (int w = 0; w < NUM_WHEELS; w++) begin
			if (w == 0)
				enc_period[w] = 4 + int'(draw_random() % 32'd4);    // Above 255 per window
			else
				enc_period[w] = 8 + int'(draw_random() % 32'd300);
		end
		@(posedge clock_50);
		enc_run <= 1'b1;
		check_speeds(1'b1);
		@(posedge clock_50);
		enc_run <= 1'b0;                       // Pulses stop, counter restarts
		check_speeds(1'b0);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		rst_n      = 1'b0;
		cmd        = '0;
		cmd_load   = 1'b0;
		enc_run    = 1'b0;
		rng        = SEED;
		checks     = 0;
		mismatches = 0;
		for (int w = 0; w < NUM_WHEELS; w++)
			enc_period[w] = 4;
		repeat (5) @(posedge clock_50);
		rst_n <= 1'b1;
		check_reset_state();
		run_random_commands();
		run_zero_commands();
		run_back_to_back();
		run_speed_tests();
		$display("Checks: %0d, mismatches: %0d", checks, mismatches);
		if (mismatches == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_NS);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- hw/robot_drive.sv
`timescale 1ns/1ps
/* Open-loop mecanum drive chain, four wheels
 * cmd is taken only with cmd_load and reaches the motors at the next PWM period
 * phase_a may be asynchronous, encoder phase B is not used
 */
module robot_drive #(
	parameter int PWM_PRESCALE  = 2048,    // ~41 us strobe at 50 MHz
	parameter int WINDOW_CYCLES = 2**23    // ~167 ms speed window
) (
	input  logic                                             clock_50,
	input  logic                                             rst_n,
	input  robot_pkg::twist_t                                cmd,
	input  logic                                             cmd_load,
	input  logic [robot_pkg::NUM_WHEELS-1:0]                 phase_a,
	output logic [robot_pkg::NUM_WHEELS-1:0]                 pwm,
	output robot_pkg::motor_dir_t [robot_pkg::NUM_WHEELS-1:0] dir,
	output robot_pkg::wheel_speeds_t                         speed
);
	import robot_pkg::*;

	// ==================================================
	// Internal signals
	// ==================================================
	logic        pwm_strobe;   // One cycle every PWM_PRESCALE
	logic        window_tick;  // End of speed window
	wheel_cmds_t wheel_cmds;   // Per-wheel targets

	// ==================================================
	// Timebase
	// ==================================================
	tick_generator #(
		.PWM_PRESCALE  (PWM_PRESCALE),
		.WINDOW_CYCLES (WINDOW_CYCLES)
	) u_ticks (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.pwm_strobe  (pwm_strobe),
		.window_tick (window_tick)
	);

	// Body command to wheel targets, 2 cycles
	mecanum_kinematics u_kin (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.cmd_load   (cmd_load),
		.wheel_cmds (wheel_cmds)
	);

	// ==================================================
	// Wheels
	// ==================================================
	for (genvar i = 0; i < NUM_WHEELS; i++) begin : g_wheel
		pwm_driver u_pwm (
			.clock_50   (clock_50),
			.rst_n      (rst_n),
			.pwm_strobe (pwm_strobe),
			.wheel_cmd  (wheel_cmds[i]),
			.pwm        (pwm[i]),
			.dir        (dir[i])
		);

		// Speed feedback only reported, no regulation
		encoder_counter u_enc (
			.clock_50    (clock_50),
			.rst_n       (rst_n),
			.window_tick (window_tick),
			.phase_a     (phase_a[i]),
			.speed       (speed[i])
		);
	end

endmodule

//--- wheel/encoder_counter.sv
`timescale 1ns/1ps
/* Rising edges of encoder phase A counted per speed window
 * Count saturates at 255 and is held in speed until the next window_tick
 * Pulses must be at least 2 clock cycles high and low to be seen
 */
module encoder_counter (
	input  logic                                clock_50,
	input  logic                                rst_n,
	input  logic                                window_tick,
	input  logic                                phase_a,
	output logic [robot_pkg::DUTY_WIDTH-1:0]    speed
);
	import robot_pkg::*;

	logic [2:0]            sync;   // Synchronizer in [1:0] and last level in [2]
	logic                  rise;
	logic [DUTY_WIDTH-1:0] count;

	// ==================================================
	// Synchronizer and edge detect
	// ==================================================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n)
			sync <= '0;
		else
			sync <= {sync[1:0], phase_a};
	end

	assign rise = sync[1] & ~sync[2];

	// ==================================================
	// Window counter and latch
	// ==================================================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			speed <= '0;
		end else if (window_tick) begin
			speed <= count;               // Already clipped
			count <= DUTY_WIDTH'(rise);   // Edge on tick opens new window
		end else if (rise && count != '1) begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- wheel/pwm_driver.sv
`timescale 1ns/1ps
/* 8-bit PWM and direction for one wheel, period of 256 strobes
 * Target is sampled only at the first strobe of a period, so no runt pulses
 * Duty 255 still leaves one low strobe per period
 */
module pwm_driver (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  pwm_strobe,
	input  robot_pkg::wheel_cmd_t wheel_cmd,
	output logic                  pwm,
	output robot_pkg::motor_dir_t dir
);
	import robot_pkg::*;

	logic [DUTY_WIDTH-1:0] phase;         // Strobe index in period
	logic [DUTY_WIDTH-1:0] duty_q;        // Duty of running period
	logic [DUTY_WIDTH-1:0] duty_next;
	logic                  period_start;

	assign period_start = (phase == '0);
	// New duty applies to the first interval already
	assign duty_next = period_start ? wheel_cmd.duty : duty_q;

	// ==================================================
	// Phase counter and output register
	// ==================================================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			phase  <= '0;
			duty_q <= '0;
			dir    <= DIR_STOP;
			pwm    <= 1'b0;
		end else if (pwm_strobe) begin
			phase <= phase + 1'b1;       // Wraps after 256
			pwm   <= (phase < duty_next); // High for first duty strobes
			if (period_start) begin
				duty_q <= wheel_cmd.duty;
				dir    <= wheel_cmd.dir;
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Brake code would short the bridge
	a_dir_legal: assert property (@(posedge clock_50) disable iff (!rst_n)
		dir != 2'b11);

	a_no_drive_at_zero: assert property (@(posedge clock_50) disable iff (!rst_n)
		pwm |-> (duty_q != '0));

endmodule

//--- hw/mecanum_kinematics.sv
`timescale 1ns/1ps
/* Mecanum mixing with the geometry factor fixed at one, 2-cycle latency
 * Integer part of each wheel sum is truncated toward zero and clipped at 255
 * Sums below one count give DIR_STOP with zero duty
 */
module mecanum_kinematics (
	input  logic                   clock_50,
	input  logic                   rst_n,
	input  robot_pkg::twist_t      cmd,
	input  logic                   cmd_load,
	output robot_pkg::wheel_cmds_t wheel_cmds
);
	import robot_pkg::*;

	localparam int SUM_W = FIX_WIDTH + 2;  // Headroom for three terms

	typedef logic signed [SUM_W-1:0] sum_t;

	// Sign-magnitude to two's complement
	function automatic logic signed [FIX_WIDTH-1:0] to_signed(fix_t f);
		logic signed [FIX_WIDTH-1:0] mag;
		mag = {1'b0, f.mag_int, f.frac};
		return f.sign ? -mag : mag;
	endfunction

	// Wheel sum to direction and clipped duty
	function automatic wheel_cmd_t to_wheel(sum_t s);
		sum_t       mag;
		wheel_cmd_t w;
		mag = s[SUM_W-1] ? -s : s;
		if (mag[SUM_W-1:FRAC_BITS+DUTY_WIDTH] != '0)
			w.duty = '1;                               // Saturate
		else
			w.duty = mag[FRAC_BITS +: DUTY_WIDTH];     // Drop fraction
		if (w.duty == '0)
			w.dir = DIR_STOP;
		else if (s[SUM_W-1])
			w.dir = DIR_REV;
		else
			w.dir = DIR_FWD;
		return w;
	endfunction

	// ==================================================
	// Stage 1, capture command
	// ==================================================
	logic                        s1_valid;
	logic signed [FIX_WIDTH-1:0] vx_q, vy_q, wz_q;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= cmd_load;
	end

	always_ff @(posedge clock_50) begin
		if (cmd_load) begin
			vx_q <= to_signed(cmd.vx);
			vy_q <= to_signed(cmd.vy);
			wz_q <= to_signed(cmd.wz);
		end
	end

	// ==================================================
	// Stage 2, mix and saturate
	// ==================================================
	sum_t vx_e, vy_e, wz_e;
	sum_t sums [NUM_WHEELS];

	always_comb begin
		vx_e    = vx_q;                  // Sign-extended
		vy_e    = vy_q;
		wz_e    = wz_q;
		sums[0] = vx_e + vy_e + wz_e;    // Wheel 1
		sums[1] = vx_e - vy_e - wz_e;    // Wheel 2
		sums[2] = vx_e - vy_e + wz_e;    // Wheel 3
		sums[3] = vx_e + vy_e - wz_e;    // Wheel 4
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			wheel_cmds <= '0;
		end else if (s1_valid) begin
			for (int i = 0; i < NUM_WHEELS; i++)
				wheel_cmds[i] <= to_wheel(sums[i]);
		end
	end

	// Stopped wheel never carries drive
	for (genvar i = 0; i < NUM_WHEELS; i++) begin : g_chk
		a_stop_zero: assert property (@(posedge clock_50) disable iff (!rst_n)
			(wheel_cmds[i].dir == DIR_STOP) |-> (wheel_cmds[i].duty == '0));
	end

endmodule

//--- hw/tick_generator.sv
`timescale 1ns/1ps
/* Free-running PWM strobe and speed-window tick, both one cycle wide
 * Both periods must be at least 2 cycles
 */
module tick_generator #(
	parameter int PWM_PRESCALE  = 2048,
	parameter int WINDOW_CYCLES = 2**23
) (
	input  logic clock_50,
	input  logic rst_n,
	output logic pwm_strobe,
	output logic window_tick
);

	// Shared counter width, sized for the longer period
	localparam int MAX_PERIOD = (PWM_PRESCALE > WINDOW_CYCLES) ? PWM_PRESCALE : WINDOW_CYCLES;
	localparam int CW         = $clog2(MAX_PERIOD);
	localparam int PERIODS [2] = '{PWM_PRESCALE, WINDOW_CYCLES};

	// ==================================================
	// Wrap-around counters, 0 = PWM, 1 = window
	// ==================================================
	for (genvar k = 0; k < 2; k++) begin : g_tick
		logic [CW-1:0] cnt;
		logic          pulse;  // Registered wrap flag

		always_ff @(posedge clock_50 or negedge rst_n) begin
			if (!rst_n) begin
				cnt   <= '0;
				pulse <= 1'b0;
			end else if (cnt == CW'(PERIODS[k] - 1)) begin
				cnt   <= '0;    // Wrap
				pulse <= 1'b1;
			end else begin
				cnt   <= cnt + 1'b1;
				pulse <= 1'b0;
			end
		end

		// Downstream counts one event per pulse
		a_single_pulse: assert property (@(posedge clock_50) disable iff (!rst_n)
			pulse |=> !pulse);
	end

	assign pwm_strobe  = g_tick[0].pulse;
	assign window_tick = g_tick[1].pulse;

endmodule

//--- common/robot_pkg.sv
/* Shared types of the drive chain
 * Velocities use the 17-bit sign-magnitude format, 8 integer and 8 fraction bits
 * A negative zero is legal on input and reads as zero
 */
package robot_pkg;

	// ==================================================
	// Fixed-point format and sizes
	// ==================================================
	localparam int FIX_WIDTH  = 17;  // Sign + integer + fraction
	localparam int FRAC_BITS  = 8;
	localparam int NUM_WHEELS = 4;
	localparam int DUTY_WIDTH = 8;   // Duty and speed count width

	// One velocity component as the host sends it
	typedef struct packed {
		logic                             sign;     // 1 = negative
		logic [FIX_WIDTH-FRAC_BITS-2:0]   mag_int;  // Integer magnitude
		logic [FRAC_BITS-1:0]             frac;     // Fraction
	} fix_t;

	// Body velocity command
	typedef struct packed {
		fix_t vx;  // Forward
		fix_t vy;  // Sideways
		fix_t wz;  // Rotation
	} twist_t;

	// ==================================================
	// Motor bridge encoding
	// ==================================================
	// Bit order is {IN1, IN2} of the H-bridge, 11 would brake
	typedef enum logic [1:0] {
		DIR_STOP = 2'b00,
		DIR_REV  = 2'b01,
		DIR_FWD  = 2'b10
	} motor_dir_t;

	// Target of one wheel
	typedef struct packed {
		motor_dir_t              dir;
		logic [DUTY_WIDTH-1:0]   duty;  // High strobes per 256
	} wheel_cmd_t;

	// Index 0 is wheel 1
	typedef wheel_cmd_t [NUM_WHEELS-1:0] wheel_cmds_t;

	// Encoder counts per window, one byte per wheel
	typedef logic [NUM_WHEELS-1:0][DUTY_WIDTH-1:0] wheel_speeds_t;

endpackage
